/* verilog/text_overlay_pkg.sv */
// fixed 3x10 text geometry with a 5x7 font; codes outside 1..53 are shown as blue cells
package text_overlay_pkg;

    // text layout
    localparam int ROW_CNT  = 3;
    localparam int ROW_SIZE = 10;

    // bus widths
    localparam int POS_W  = 10;
    localparam int CODE_W = 8;
    localparam int ROW_W  = 2;
    localparam int COL_W  = 4;

    // dot geometry, lit part of each dot then a 2 px gap
    localparam int DOT_PITCH  = 10;
    localparam int DOT_LEN    = 8;
    localparam int GLYPH_COLS = 5;
    localparam int GLYPH_ROWS = 7;
    localparam int GLYPH_W    = GLYPH_COLS * DOT_PITCH;
    localparam int GLYPH_H    = GLYPH_ROWS * DOT_PITCH;

    // cell pitches, one row pitch for every row
    localparam int CHAR_PITCH = 60;
    localparam int ROW_PITCH  = 100;

    // top-left corner of the text region
    localparam int ORIGIN_X = 30;
    localparam int ORIGIN_Y = 30;

    // character codes
    localparam logic [CODE_W-1:0] CODE_SPACE = 8'd27;
    localparam logic [CODE_W-1:0] CODE_MIN   = 8'd1;
    localparam logic [CODE_W-1:0] CODE_MAX   = 8'd53;

    // colours packed as {blue, green, red}
    typedef logic [23:0] color_t;

    localparam color_t COLOR_BLACK = 24'h00_00_00;
    localparam color_t COLOR_WHITE = 24'hff_ff_ff;
    localparam color_t COLOR_BLUE  = 24'hff_00_00;

    // msb is the top-left dot, five dots per glyph row
    localparam logic [GLYPH_COLS*GLYPH_ROWS-1:0] font_table [CODE_MIN:CODE_MAX] = '{
        // lower case a to z
        35'b00000_00000_01110_00001_01111_10001_01111,
        35'b10000_10000_10110_11001_10001_10001_11110,
        35'b00000_00000_01110_10000_10000_10001_01110,
        35'b00001_00001_01101_10011_10001_10001_01111,
        35'b00000_00000_01110_10001_11111_10000_01110,
        35'b00110_01001_01000_11100_01000_01000_01000,
        35'b00000_00000_01111_10001_01111_00001_01110,
        35'b10000_10000_10110_11001_10001_10001_10001,
        35'b00100_00000_00100_01100_00100_00100_01110,
        35'b00001_00000_00011_00001_00001_01001_00110,
        35'b10000_10000_10010_10100_11000_10100_10010,
        35'b01100_00100_00100_00100_00100_00100_01110,
        35'b00000_00000_11010_10101_10101_10101_10101,
        35'b00000_00000_10110_11001_10001_10001_10001,
        35'b00000_00000_01110_10001_10001_10001_01110,
        35'b00000_00000_11110_10001_11110_10000_10000,
        35'b00000_00000_01111_10001_01111_00001_00001,
        35'b00000_00000_10110_11001_10000_10000_10000,
        35'b00000_00000_01110_10000_01110_00001_11110,
        35'b01000_11100_01000_01000_01000_01001_00110,
        35'b00000_00000_10001_10001_10001_10011_01101,
        35'b00000_00000_10001_10001_10001_01010_00100,
        35'b00000_00000_10001_10001_10101_10101_01010,
        35'b00000_00000_10001_01010_00100_01010_10001,
        35'b00000_00000_10001_10001_01111_00001_01110,
        35'b00000_00000_11111_00010_00100_01000_11111,
        // space, valid but never lit
        35'b00000_00000_00000_00000_00000_00000_00000,
        // upper case A to Z
        35'b00100_01010_10001_10001_11111_10001_10001,
        35'b11110_01001_01001_01110_01001_01001_11110,
        35'b01110_10001_10000_10000_10000_10001_01110,
        35'b11110_01001_01001_01001_01001_01001_11110,
        35'b11111_10000_10000_11111_10000_10000_11111,
        35'b11111_10000_10000_11110_10000_10000_10000,
        35'b01110_10001_10000_10011_10001_10001_01111,
        35'b10001_10001_10001_11111_10001_10001_10001,
        35'b01110_00100_00100_00100_00100_00100_01110,
        35'b00111_00010_00010_00010_00010_10010_01100,
        35'b10001_10010_10100_11000_10100_10010_10001,
        35'b10000_10000_10000_10000_10000_10000_11111,
        35'b10001_11011_10101_10101_10001_10001_10001,
        35'b10001_10001_11001_10101_10011_10001_10001,
        35'b01110_10001_10001_10001_10001_10001_01110,
        35'b11110_10001_10001_11110_10000_10000_10000,
        35'b01110_10001_10001_10001_10101_10010_01101,
        35'b11110_10001_10001_11110_10100_10010_10001,
        35'b01110_10001_10000_01110_00001_10001_01110,
        35'b11111_00100_00100_00100_00100_00100_00100,
        35'b10001_10001_10001_10001_10001_10001_01110,
        35'b10001_10001_10001_10001_10001_01010_00100,
        35'b10001_10001_10001_10101_10101_10101_01010,
        35'b10001_10001_01010_00100_01010_10001_10001,
        35'b10001_10001_10001_01010_00100_00100_00100,
        35'b11111_00001_00010_00100_01000_10000_11111
    };

endpackage

/* verilog/text_store.sv */
// writes land on the next edge; out-of-range write addresses are dropped, counts clamp at 10
`timescale 1ns/1ns

module text_store (
    input  logic                                        i_clk,
    input  logic                                        i_rst,
    input  logic                                        i_char_we,
    input  logic                                        i_count_we,
    input  logic [text_overlay_pkg::ROW_W-1:0]          i_wr_row,
    input  logic [text_overlay_pkg::COL_W-1:0]          i_wr_col,
    input  logic [text_overlay_pkg::CODE_W-1:0]         i_wr_code,
    input  logic [text_overlay_pkg::COL_W-1:0]          i_wr_count,
    input  logic [text_overlay_pkg::ROW_W-1:0]          i_rd_row,
    input  logic [text_overlay_pkg::COL_W-1:0]          i_rd_col,
    output logic [text_overlay_pkg::CODE_W-1:0]         o_rd_code,
    output logic [text_overlay_pkg::ROW_CNT-1:0][text_overlay_pkg::COL_W-1:0] o_row_count
);
    import text_overlay_pkg::*;

    logic [CODE_W-1:0] codes [ROW_CNT][ROW_SIZE];
    logic [COL_W-1:0]  count_clamped;

    // a row never shows more than ROW_SIZE cells
    assign count_clamped = (i_wr_count > COL_W'(ROW_SIZE)) ? COL_W'(ROW_SIZE) : i_wr_count;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int r = 0; r < ROW_CNT; r++) begin
                for (int c = 0; c < ROW_SIZE; c++) begin
                    codes[r][c] <= CODE_SPACE;
                end
            end
        end else if (i_char_we) begin
            for (int r = 0; r < ROW_CNT; r++) begin
                for (int c = 0; c < ROW_SIZE; c++) begin
                    if (i_wr_row == ROW_W'(r) && i_wr_col == COL_W'(c)) begin
                        codes[r][c] <= i_wr_code;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_row_count <= '0;
        end else if (i_count_we) begin
            for (int r = 0; r < ROW_CNT; r++) begin
                if (i_wr_row == ROW_W'(r)) begin
                    o_row_count[r] <= count_clamped;
                end
            end
        end
    end

    // read port, guarded since the index widths reach past the array
    assign o_rd_code = (i_rd_row < ROW_W'(ROW_CNT) && i_rd_col < COL_W'(ROW_SIZE)) ?
                       codes[i_rd_row][i_rd_col] : CODE_SPACE;

    // writer must stay inside the 3x10 store
    a_wr_row_range: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_char_we || i_count_we) |-> (i_wr_row < ROW_W'(ROW_CNT)));
    a_wr_col_range: assert property (@(posedge i_clk) disable iff (i_rst)
        i_char_we |-> (i_wr_col < COL_W'(ROW_SIZE)));

endmodule

/* verilog/char_locator.sv */
// purely combinational; offsets and indices are zero whenever the pixel is outside the text
`timescale 1ns/1ns

module char_locator (
    input  logic [text_overlay_pkg::POS_W-1:0]  i_x_pos,
    input  logic [text_overlay_pkg::POS_W-1:0]  i_y_pos,
    input  logic [text_overlay_pkg::ROW_CNT-1:0][text_overlay_pkg::COL_W-1:0] i_row_count,
    output logic [text_overlay_pkg::ROW_W-1:0]  o_row,
    output logic [text_overlay_pkg::COL_W-1:0]  o_col,
    output logic [text_overlay_pkg::POS_W-1:0]  o_off_x,
    output logic [text_overlay_pkg::POS_W-1:0]  o_off_y,
    output logic                                o_in_region
);
    import text_overlay_pkg::*;

    logic             in_y;
    logic             in_x;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [COL_W-1:0] count;
    logic [POS_W-1:0] row_base;
    logic [POS_W-1:0] col_base;

    // row chain, one band per row pitch
    always_comb begin
        in_y     = 1'b0;
        row      = '0;
        row_base = POS_W'(ORIGIN_Y);
        for (int r = 0; r < ROW_CNT; r++) begin
            if (i_y_pos >= POS_W'(ORIGIN_Y + r * ROW_PITCH) &&
                i_y_pos <  POS_W'(ORIGIN_Y + (r + 1) * ROW_PITCH)) begin
                in_y     = 1'b1;
                row      = ROW_W'(r);
                row_base = POS_W'(ORIGIN_Y + r * ROW_PITCH);
            end
        end
    end

    assign count = i_row_count[row];

    // column chain, stops at this row's count
    always_comb begin
        in_x     = 1'b0;
        col      = '0;
        col_base = POS_W'(ORIGIN_X);
        for (int c = 0; c < ROW_SIZE; c++) begin
            if (COL_W'(c) < count &&
                i_x_pos >= POS_W'(ORIGIN_X + c * CHAR_PITCH) &&
                i_x_pos <  POS_W'(ORIGIN_X + (c + 1) * CHAR_PITCH)) begin
                in_x     = 1'b1;
                col      = COL_W'(c);
                col_base = POS_W'(ORIGIN_X + c * CHAR_PITCH);
            end
        end
    end

    assign o_in_region = in_y & in_x;
    assign o_row       = o_in_region ? row : '0;
    assign o_col       = o_in_region ? col : '0;
    assign o_off_x     = o_in_region ? (i_x_pos - col_base) : '0;
    assign o_off_y     = o_in_region ? (i_y_pos - row_base) : '0;

endmodule

/* verilog/dot_shader.sv */
// one cycle from offsets to colour; output is black while reset is held
`timescale 1ns/1ns

module dot_shader (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic [text_overlay_pkg::CODE_W-1:0] i_code,
    input  logic [text_overlay_pkg::POS_W-1:0]  i_off_x,
    input  logic [text_overlay_pkg::POS_W-1:0]  i_off_y,
    input  logic                                i_in_region,
    output text_overlay_pkg::color_t            o_color
);
    import text_overlay_pkg::*;

    logic                               code_valid;
    logic                               in_glyph;
    logic                               in_dot;
    logic                               lit;
    logic [GLYPH_COLS*GLYPH_ROWS-1:0]   glyph;
    logic [POS_W-1:0]                   dot_col;
    logic [POS_W-1:0]                   dot_row;
    logic [POS_W-1:0]                   rem_x;
    logic [POS_W-1:0]                   rem_y;
    logic [POS_W-1:0]                   bit_idx;
    color_t                             color_d;

    assign code_valid = (i_code >= CODE_MIN) && (i_code <= CODE_MAX);

    always_comb begin
        glyph = '0;
        if (code_valid) begin
            glyph = font_table[i_code];
        end
    end

    // which dot, and where inside it
    assign dot_col = i_off_x / POS_W'(DOT_PITCH);
    assign dot_row = i_off_y / POS_W'(DOT_PITCH);
    assign rem_x   = i_off_x % POS_W'(DOT_PITCH);
    assign rem_y   = i_off_y % POS_W'(DOT_PITCH);

    assign in_glyph = (i_off_x < POS_W'(GLYPH_W)) && (i_off_y < POS_W'(GLYPH_H));
    assign in_dot   = (rem_x < POS_W'(DOT_LEN)) && (rem_y < POS_W'(DOT_LEN));
    assign bit_idx  = dot_row * POS_W'(GLYPH_COLS) + dot_col;
    assign lit      = in_glyph && in_dot && glyph[GLYPH_COLS*GLYPH_ROWS-1 - bit_idx];

    always_comb begin
        if (!i_in_region) begin
            color_d = COLOR_BLACK;
        end else if (!code_valid) begin
            // unknown code fills the whole cell
            color_d = COLOR_BLUE;
        end else if (lit) begin
            color_d = COLOR_WHITE;
        end else begin
            color_d = COLOR_BLACK;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_color <= COLOR_BLACK;
        end else begin
            o_color <= color_d;
        end
    end

    // offsets handed over in the region stay inside one cell
    a_off_in_cell: assert property (@(posedge i_clk) disable iff (i_rst)
        i_in_region |-> (i_off_x < POS_W'(CHAR_PITCH) && i_off_y < POS_W'(ROW_PITCH)));

endmodule

/* verilog/text_overlay.sv */
// free-running pixel stream, no valid or stall; colour follows the pixel by one clock
`timescale 1ns/1ns

module text_overlay (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic [text_overlay_pkg::POS_W-1:0]  i_x_pos,
    input  logic [text_overlay_pkg::POS_W-1:0]  i_y_pos,
    input  logic                                i_char_we,
    input  logic                                i_count_we,
    input  logic [text_overlay_pkg::ROW_W-1:0]  i_wr_row,
    input  logic [text_overlay_pkg::COL_W-1:0]  i_wr_col,
    input  logic [text_overlay_pkg::CODE_W-1:0] i_wr_code,
    input  logic [text_overlay_pkg::COL_W-1:0]  i_wr_count,
    output logic [7:0]                          o_red,
    output logic [7:0]                          o_green,
    output logic [7:0]                          o_blue
);
    import text_overlay_pkg::*;

    logic [ROW_CNT-1:0][COL_W-1:0] row_count;
    logic [CODE_W-1:0]             rd_code;
    logic [ROW_W-1:0]              row;
    logic [COL_W-1:0]              col;
    logic [POS_W-1:0]              off_x;
    logic [POS_W-1:0]              off_y;
    logic                          in_region;
    color_t                        color;

    text_store i_text_store (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_char_we   (i_char_we),
        .i_count_we  (i_count_we),
        .i_wr_row    (i_wr_row),
        .i_wr_col    (i_wr_col),
        .i_wr_code   (i_wr_code),
        .i_wr_count  (i_wr_count),
        .i_rd_row    (row),
        .i_rd_col    (col),
        .o_rd_code   (rd_code),
        .o_row_count (row_count)
    );

    char_locator i_char_locator (
        .i_x_pos     (i_x_pos),
        .i_y_pos     (i_y_pos),
        .i_row_count (row_count),
        .o_row       (row),
        .o_col       (col),
        .o_off_x     (off_x),
        .o_off_y     (off_y),
        .o_in_region (in_region)
    );

    dot_shader i_dot_shader (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_code      (rd_code),
        .i_off_x     (off_x),
        .i_off_y     (off_y),
        .i_in_region (in_region),
        .o_color     (color)
    );

    // colour word is {blue, green, red}
    assign o_blue  = color[23:16];
    assign o_green = color[15:8];
    assign o_red   = color[7:0];

endmodule

/* tests/tb_clock.sv */
// free-running clock with an 8 ns period, starts low so the first rising edge is at 4 ns
`timescale 1ns/1ns

module tb_clock (
    output logic o_clk
);
    localparam int HALF_PERIOD = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

/* tests/text_overlay_tb.sv */
// needs the 3x10 layout of the package; fixed seed, so every run drives the same pixels
`timescale 1ns/1ns

module text_overlay_tb;
    import text_overlay_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int SEED          = 32'h4f63_72f7;
    localparam int CODE_UPPER_A  = 28;
    localparam int CODE_UPPER_E  = 32;
    localparam int REGION_BOTTOM = ORIGIN_Y + ROW_CNT * ROW_PITCH;
    // cycle budget per test: reset, bounds, glyphs, gaps, unknown codes, writes
    localparam int TEST_CYCLES   = 400 + 4000 + 3100 + 1600 + 7200 + 800;
    localparam int TIMEOUT_NS    = (TEST_CYCLES + 1000) * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic [POS_W-1:0]  x_pos;
    logic [POS_W-1:0]  y_pos;
    logic              char_we;
    logic              count_we;
    logic [ROW_W-1:0]  wr_row;
    logic [COL_W-1:0]  wr_col;
    logic [CODE_W-1:0] wr_code;
    logic [COL_W-1:0]  wr_count;
    logic [7:0]        red;
    logic [7:0]        green;
    logic [7:0]        blue;

    // shadow of the text store and the colour expected one cycle later
    int         shadow_code [ROW_CNT][ROW_SIZE];
    int         shadow_count [ROW_CNT];
    logic [7:0] exp_red;
    logic [7:0] exp_green;
    logic [7:0] exp_blue;
    logic       check_en = 1'b0;

    int mismatch_count = 0;
    int err_mark = 0;
    int test_idx = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    tb_clock i_tb_clock (.o_clk(clk));

    text_overlay i_text_overlay (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_x_pos    (x_pos),
        .i_y_pos    (y_pos),
        .i_char_we  (char_we),
        .i_count_we (count_we),
        .i_wr_row   (wr_row),
        .i_wr_col   (wr_col),
        .i_wr_code  (wr_code),
        .i_wr_count (wr_count),
        .o_red      (red),
        .o_green    (green),
        .o_blue     (blue)
    );

    // location and shading rules applied to the shadow text
    function automatic color_t expected_color(int x, int y);
        int row;
        int col;
        int ox;
        int oy;
        int code;
        logic [GLYPH_COLS*GLYPH_ROWS-1:0] bitmap;
        if (y < ORIGIN_Y || y >= REGION_BOTTOM) return COLOR_BLACK;
        row = (y - ORIGIN_Y) / ROW_PITCH;
        oy  = (y - ORIGIN_Y) % ROW_PITCH;
        if (x < ORIGIN_X || x >= ORIGIN_X + shadow_count[row] * CHAR_PITCH) return COLOR_BLACK;
        col  = (x - ORIGIN_X) / CHAR_PITCH;
        ox   = (x - ORIGIN_X) % CHAR_PITCH;
        code = shadow_code[row][col];
        if (code < CODE_MIN || code > CODE_MAX) return COLOR_BLUE;
        if (ox >= GLYPH_W || oy >= GLYPH_H) return COLOR_BLACK;
        if (ox % DOT_PITCH >= DOT_LEN || oy % DOT_PITCH >= DOT_LEN) return COLOR_BLACK;
        bitmap = font_table[code];
        if (bitmap[GLYPH_COLS*GLYPH_ROWS-1 - ((oy / DOT_PITCH) * GLYPH_COLS + ox / DOT_PITCH)])
            return COLOR_WHITE;
        return COLOR_BLACK;
    endfunction

    // expected colour from the old text, then this edge's writes land in the shadow
    always @(posedge clk) begin : model
        color_t next_color;
        next_color = rst ? COLOR_BLACK : expected_color(x_pos, y_pos);
        exp_red   <= next_color[7:0];
        exp_green <= next_color[15:8];
        exp_blue  <= next_color[23:16];
        check_en  <= 1'b1;
        if (rst) begin
            for (int r = 0; r < ROW_CNT; r++) begin
                shadow_count[r] <= 0;
                for (int c = 0; c < ROW_SIZE; c++) begin
                    shadow_code[r][c] <= CODE_SPACE;
                end
            end
        end else begin
            if (char_we) shadow_code[wr_row][wr_col] <= wr_code;
            if (count_we) shadow_count[wr_row] <= (wr_count > ROW_SIZE) ? ROW_SIZE : wr_count;
        end
    end

    task automatic report_mismatch(input string name, input logic [7:0] exp,
                                   input logic [7:0] act);
        mismatch_count++;
        $display("FAIL %s: expected %02h, actual %02h at %0t ns", name, exp, act, $time);
    endtask

    a_red: assert property (@(posedge clk) check_en |-> red == exp_red)
        else report_mismatch("o_red", $sampled(exp_red), $sampled(red));
    a_green: assert property (@(posedge clk) check_en |-> green == exp_green)
        else report_mismatch("o_green", $sampled(exp_green), $sampled(green));
    a_blue: assert property (@(posedge clk) check_en |-> blue == exp_blue)
        else report_mismatch("o_blue", $sampled(exp_blue), $sampled(blue));

    task automatic drive_cycle(input int x, input int y, input int cwe, input int nwe,
                               input int r, input int c, input int code, input int n);
        @(negedge clk);
        x_pos    = POS_W'(x);
        y_pos    = POS_W'(y);
        char_we  = cwe[0];
        count_we = nwe[0];
        wr_row   = ROW_W'(r);
        wr_col   = COL_W'(c);
        wr_code  = CODE_W'(code);
        wr_count = COL_W'(n);
    endtask

    task automatic set_pixel(input int x, input int y);
        drive_cycle(x, y, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic drive_cell_pixel(input int r, input int c, input int ox, input int oy);
        set_pixel(ORIGIN_X + c * CHAR_PITCH + ox, ORIGIN_Y + r * ROW_PITCH + oy);
    endtask

    task automatic write_char(input int r, input int c, input int code);
        drive_cycle(0, 0, 1, 0, r, c, code, 0);
    endtask

    task automatic write_count(input int r, input int n);
        drive_cycle(0, 0, 0, 1, r, 0, 0, n);
    endtask

    // two idle pixels so the last check has run before counting
    task automatic finish_test(input string name);
        int errs;
        set_pixel(0, 0);
        set_pixel(0, 0);
        errs = mismatch_count - err_mark;
        err_mark = mismatch_count;
        test_idx++;
        if (errs == 0) tests_passed++;
        else tests_failed++;
        $display("test %0d %s: done, %0d mismatches", test_idx, name, errs);
    endtask

    initial begin
        int r;
        int c;
        int k;
        int x;
        int y;
        int ox;
        int oy;
        int lim;
        int row_counts [ROW_CNT];
        void'($urandom(SEED));
        rst = 1'b1;
        x_pos = '0;
        y_pos = '0;
        char_we = 1'b0;
        count_we = 1'b0;
        wr_row = '0;
        wr_col = '0;
        wr_code = '0;
        wr_count = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        repeat (200) set_pixel($urandom_range(0, 1023), $urandom_range(0, 1023));
        // full counts but no character writes, so every cell shows its reset code
        for (r = 0; r < ROW_CNT; r++) write_count(r, ROW_SIZE);
        repeat (100) begin
            drive_cell_pixel($urandom_range(0, ROW_CNT - 1), $urandom_range(0, ROW_SIZE - 1),
                             $urandom_range(0, CHAR_PITCH - 1), $urandom_range(0, ROW_PITCH - 1));
        end
        finish_test("reset and empty text");

        // unknown codes everywhere, so every in-region pixel is blue
        row_counts = '{3, 10, 5};
        for (r = 0; r < ROW_CNT; r++) begin
            write_count(r, row_counts[r]);
            for (c = 0; c < ROW_SIZE; c++) write_char(r, c, 0);
        end
        for (k = 0; k < 4; k++) begin
            y = (k < 2) ? ORIGIN_Y - 1 + k : REGION_BOTTOM - 3 + k;
            for (x = ORIGIN_X - 2; x <= ORIGIN_X + ROW_SIZE * CHAR_PITCH + 1; x++) set_pixel(x, y);
        end
        for (y = ORIGIN_Y - 2; y <= REGION_BOTTOM + 1; y++) begin
            r = (y < ORIGIN_Y) ? 0 : (y - ORIGIN_Y) / ROW_PITCH;
            if (r >= ROW_CNT) r = ROW_CNT - 1;
            lim = ORIGIN_X + row_counts[r] * CHAR_PITCH;
            for (k = 0; k < 4; k++) set_pixel((k < 2) ? ORIGIN_X - 1 + k : lim - 3 + k, y);
        end
        finish_test("region bounds");

        for (r = 0; r < ROW_CNT; r++) begin
            row_counts[r] = $urandom_range(1, ROW_SIZE);
            write_count(r, row_counts[r]);
            for (c = 0; c < ROW_SIZE; c++) write_char(r, c, $urandom_range(1, 53));
        end
        repeat (3000) begin
            r = $urandom_range(0, ROW_CNT - 1);
            c = $urandom_range(0, row_counts[r] - 1);
            drive_cell_pixel(r, c, $urandom_range(0, GLYPH_W - 1), $urandom_range(0, GLYPH_H - 1));
        end
        finish_test("glyph drawing");

        repeat (1500) begin
            r = $urandom_range(0, ROW_CNT - 1);
            c = $urandom_range(0, row_counts[r] - 1);
            ox = DOT_PITCH * $urandom_range(0, GLYPH_COLS - 1) + $urandom_range(0, DOT_PITCH - 1);
            oy = DOT_PITCH * $urandom_range(0, GLYPH_ROWS - 1) + $urandom_range(0, DOT_PITCH - 1);
            case ($urandom_range(0, 3))
                0: ox = $urandom_range(GLYPH_W, CHAR_PITCH - 1);
                1: oy = $urandom_range(GLYPH_H, ROW_PITCH - 1);
                2: ox = (ox / DOT_PITCH) * DOT_PITCH + $urandom_range(DOT_LEN, DOT_PITCH - 1);
                default: oy = (oy / DOT_PITCH) * DOT_PITCH + $urandom_range(DOT_LEN, DOT_PITCH - 1);
            endcase
            drive_cell_pixel(r, c, ox, oy);
        end
        finish_test("dot and glyph gaps");

        for (r = 0; r < ROW_CNT; r++) begin
            write_count(r, ROW_SIZE);
            for (c = 0; c < ROW_SIZE; c++) begin
                write_char(r, c, (r == 0 && c == 0) ? 0 : $urandom_range(54, 255));
            end
        end
        for (oy = 0; oy < ROW_PITCH; oy++) begin
            for (ox = 0; ox < CHAR_PITCH; ox++) drive_cell_pixel(0, 0, ox, oy);
        end
        repeat (1000) begin
            drive_cell_pixel($urandom_range(0, ROW_CNT - 1), $urandom_range(0, ROW_SIZE - 1),
                             $urandom_range(0, CHAR_PITCH - 1), $urandom_range(0, ROW_PITCH - 1));
        end
        finish_test("unknown codes");

        // count of 15 must clamp, then a glyph swap while the stream keeps running
        write_count(1, 15);
        for (c = 0; c < ROW_SIZE; c++) write_char(1, c, CODE_UPPER_A);
        for (oy = 0; oy < DOT_LEN; oy++) begin
            for (x = ORIGIN_X + 9 * CHAR_PITCH - 2; x <= ORIGIN_X + ROW_SIZE * CHAR_PITCH + 9; x++)
                set_pixel(x, ORIGIN_Y + ROW_PITCH + oy);
        end
        write_count(0, 1);
        write_char(0, 0, CODE_UPPER_A);
        for (k = 0; k < 100; k++) begin
            drive_cycle(ORIGIN_X + k % GLYPH_W, ORIGIN_Y + k / GLYPH_W, (k == 50), 0,
                        0, 0, CODE_UPPER_E, 0);
        end
        finish_test("count clamp and overwrite");

        $display("tests run: %0d, passed: %0d, failed: %0d, mismatches: %0d",
                 test_idx, tests_passed, tests_failed, mismatch_count);
        if (tests_failed == 0 && mismatch_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within their cycle budget");
        $display("Verification failed");
        $finish;
    end

endmodule

/* build.f */
verilog/text_overlay_pkg.sv
verilog/text_store.sv
verilog/char_locator.sv
verilog/dot_shader.sv
verilog/text_overlay.sv
tests/tb_clock.sv
tests/text_overlay_tb.sv

/* Bender.yml */
package:
  name: text_overlay

sources:
  # design, package first
  - verilog/text_overlay_pkg.sv
  - verilog/text_store.sv
  - verilog/char_locator.sv
  - verilog/dot_shader.sv
  - verilog/text_overlay.sv

  # testbench
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/text_overlay_tb.sv
